// ==== Makefile ====
TOOL    = verilator
FLAGS   = --binary --assert -Wno-fatal
TOP     = tb_lcd_scanout
FLIST   = all.f
OBJ_DIR = obj_dir
LOG     = sim.log
PASS    = Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS)" $(LOG) && echo "test passed" || (echo "test failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
+incdir+source
source/lcd_pkg.sv
source/lcd_bus_if.sv
source/lcd_timing.sv
source/lcd_host_regs.sv
source/lcd_pixel_out.sv
source/lcd_scanout_top.sv
test/tb_lcd_checker.sv
test/tb_lcd_scanout.sv

// ==== source/lcd_bus_if.sv ====
`timescale 1ns/10ps
`include "lcd_defines.svh"

interface lcd_bus_if;

    logic               valid;      // held until ready
    logic [`BUS_W-1:0]  addr;
    logic [`BUS_W-1:0]  wdata;
    logic [3:0]         wstrb;      // zero means read
    logic [`BUS_W-1:0]  rdata;      // valid with ready
    logic               ready;      // one-cycle pulse

    modport host (
        output valid, addr, wdata, wstrb,
        input  rdata, ready
    );

    modport slave (
        input  valid, addr, wdata, wstrb,
        output rdata, ready
    );

endinterface

// ==== source/lcd_defines.svh ====
`ifndef LCD_DEFINES_SVH
`define LCD_DEFINES_SVH

// panel geometry
`define LCD_WIDTH       1024
`define LCD_HEIGHT      600

`define H_FRONT_PORCH   210
`define H_PULSE         16
`define H_BACK_PORCH    182

`define V_FRONT_PORCH   45
`define V_PULSE         5
`define V_BACK_PORCH    0

// last count values, a line is H_TOTAL+1 clocks
`define H_TOTAL (`LCD_WIDTH + `H_FRONT_PORCH + `H_PULSE + `H_BACK_PORCH)
`define V_TOTAL (`LCD_HEIGHT + `V_FRONT_PORCH + `V_PULSE + `V_BACK_PORCH)

`define X_W             11          // column counter
`define Y_W             10          // line counter
`define BUS_W           32          // host data width
`define LB_AW           10          // line buffer address

// host address map
`define LB_SEL_BIT      12          // set selects the line buffer
`define UNMAPPED_WORD   32'hDEADBEEF

`endif

// ==== source/lcd_host_regs.sv ====
`timescale 1ns/10ps
`include "lcd_defines.svh"

module lcd_host_regs (
    input  logic                pclk,
    input  logic                resetn,
    lcd_bus_if.slave            bus,
    output logic                lb_we_o,
    output logic [`LB_AW-1:0]   lb_waddr_o,
    output lcd_pkg::rgb565_u    lb_wdata_o,
    output logic                show_buffer_o,
    output lcd_pkg::rgb565_u    fill_color_o
);
    import lcd_pkg::*;

    logic [`BUS_W-1:0]  ctrl_q;
    rgb565_u            color_q;
    logic               ready_q;
    logic [`BUS_W-1:0]  rdata_q;
    logic [`BUS_W-1:0]  color_word;
    logic [`BUS_W-1:0]  color_next;
    reg_idx_e           reg_idx;
    logic               take;
    logic               is_write;
    logic               lb_sel;

    function automatic logic [`BUS_W-1:0] byte_merge(
        input logic [`BUS_W-1:0] old_v,
        input logic [`BUS_W-1:0] new_v,
        input logic [3:0]        strb
    );
        logic [`BUS_W-1:0] res;
        int                i;
        res = old_v;
        for (i = 0; i < 4; i++) begin
            if (strb[i]) res[i*8 +: 8] = new_v[i*8 +: 8];
        end
        return res;
    endfunction

    assign take       = bus.valid && !ready_q;     // first cycle of a transfer
    assign is_write   = |bus.wstrb;
    assign lb_sel     = bus.addr[`LB_SEL_BIT];
    assign reg_idx    = reg_idx_e'(bus.addr[4:2]);
    assign color_word = {16'h0000, color_q.raw};
    assign color_next = byte_merge(color_word, bus.wdata, bus.wstrb);

    always_ff @(posedge pclk) begin
        if (!resetn) begin
            ready_q <= 1'b0;
            lb_we_o <= 1'b0;
            ctrl_q  <= '0;
            color_q <= '0;
        end else begin
            ready_q <= take;
            lb_we_o <= take && is_write && lb_sel;  // any strobe writes the whole entry
            if (take && is_write && !lb_sel) begin
                case (reg_idx)
                    REG_CTRL:  ctrl_q <= byte_merge(ctrl_q, bus.wdata, bus.wstrb);
                    REG_COLOR: color_q.raw <= color_next[15:0];
                    default: ;                      // unmapped, dropped
                endcase
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (take) begin
            lb_waddr_o     <= bus.addr[`LB_AW+1:2];
            lb_wdata_o.raw <= bus.wdata[15:0];
            if (lb_sel) begin
                rdata_q <= `UNMAPPED_WORD;          // buffer is write-only
            end else begin
                case (reg_idx)
                    REG_CTRL:  rdata_q <= ctrl_q;
                    REG_COLOR: rdata_q <= color_word;
                    default:   rdata_q <= `UNMAPPED_WORD;
                endcase
            end
        end
    end

    assign bus.ready     = ready_q;
    assign bus.rdata     = rdata_q;
    assign show_buffer_o = ctrl_q[0];
    assign fill_color_o  = color_q;

    a_ready_pulse: assert property (
        @(posedge pclk) disable iff (!resetn) bus.ready |=> !bus.ready
    );
    a_ready_after_valid: assert property (
        @(posedge pclk) disable iff (!resetn) bus.ready |-> $past(bus.valid)
    );

endmodule

// ==== source/lcd_pixel_out.sv ====
`timescale 1ns/10ps
`include "lcd_defines.svh"

module lcd_pixel_out (
    input  logic                pclk,
    input  logic                resetn,
    input  logic                lb_we_i,
    input  logic [`LB_AW-1:0]   lb_waddr_i,
    input  lcd_pkg::rgb565_u    lb_wdata_i,
    input  logic                show_buffer_i,
    input  lcd_pkg::rgb565_u    fill_color_i,
    input  logic                hsync_act_i,
    input  logic                vsync_act_i,
    input  logic                de_i,
    input  logic [`LB_AW-1:0]   rd_addr_i,
    output logic                lcd_de_o,
    output logic                lcd_hsync_o,
    output logic                lcd_vsync_o,
    output logic [4:0]          lcd_r_o,
    output logic [5:0]          lcd_g_o,
    output logic [4:0]          lcd_b_o
);
    import lcd_pkg::*;

    localparam int LB_DEPTH = 1 << `LB_AW;

    logic [15:0] line_buf [0:LB_DEPTH-1];   // one visible line
    rgb565_u     pix_q;

    // host write port
    always_ff @(posedge pclk) begin
        if (lb_we_i) begin
            line_buf[lb_waddr_i] <= lb_wdata_i.raw;
        end
    end

    // scan read port, source picked as the word is fetched
    always_ff @(posedge pclk) begin
        if (show_buffer_i) begin
            pix_q.raw <= line_buf[rd_addr_i];
        end else begin
            pix_q <= fill_color_i;
        end
    end

    // delay DE and syncs by the read latency
    always_ff @(posedge pclk) begin
        if (!resetn) begin
            lcd_de_o    <= 1'b0;
            lcd_hsync_o <= 1'b1;                    // inactive high
            lcd_vsync_o <= 1'b1;
        end else begin
            lcd_de_o    <= de_i;
            lcd_hsync_o <= ~hsync_act_i;
            lcd_vsync_o <= ~vsync_act_i;
        end
    end

    assign lcd_r_o = pix_q.rgb.r;
    assign lcd_g_o = pix_q.rgb.g;
    assign lcd_b_o = pix_q.rgb.b;

endmodule

// ==== source/lcd_pkg.sv ====
package lcd_pkg;

    // field view of one RGB565 word, red in the top bits
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_s;

    // host writes raw words, the output stage reads fields
    typedef union packed {
        logic [15:0] raw;
        rgb565_s     rgb;
    } rgb565_u;

    // register word offsets, addr[4:2]
    typedef enum logic [2:0] {
        REG_CTRL  = 3'd0,           // bit 0 selects line buffer
        REG_COLOR = 3'd1            // solid fill colour
    } reg_idx_e;

endpackage

// ==== source/lcd_scanout_top.sv ====
`timescale 1ns/10ps
`include "lcd_defines.svh"

module lcd_scanout_top (
    input  logic                pclk,
    input  logic                resetn,
    input  logic                host_valid_i,
    input  logic [`BUS_W-1:0]   host_addr_i,
    input  logic [`BUS_W-1:0]   host_wdata_i,
    input  logic [3:0]          host_wstrb_i,
    output logic [`BUS_W-1:0]   host_rdata_o,
    output logic                host_ready_o,
    output logic                lcd_de_o,
    output logic                lcd_hsync_o,
    output logic                lcd_vsync_o,
    output logic [4:0]          lcd_r_o,
    output logic [5:0]          lcd_g_o,
    output logic [4:0]          lcd_b_o
);
    import lcd_pkg::*;

    logic               hsync_act;
    logic               vsync_act;
    logic               de_raw;
    logic [`LB_AW-1:0]  rd_addr;
    logic               lb_we;
    logic [`LB_AW-1:0]  lb_waddr;
    rgb565_u            lb_wdata;
    logic               show_buffer;
    rgb565_u            fill_color;

    lcd_bus_if u_bus ();

    // host pins onto the internal bus
    assign u_bus.valid  = host_valid_i;
    assign u_bus.addr   = host_addr_i;
    assign u_bus.wdata  = host_wdata_i;
    assign u_bus.wstrb  = host_wstrb_i;
    assign host_rdata_o = u_bus.rdata;
    assign host_ready_o = u_bus.ready;

    lcd_timing u_timing (
        .pclk        (pclk),
        .resetn      (resetn),
        .hsync_act_o (hsync_act),
        .vsync_act_o (vsync_act),
        .de_o        (de_raw),
        .rd_addr_o   (rd_addr)
    );

    lcd_host_regs u_regs (
        .pclk          (pclk),
        .resetn        (resetn),
        .bus           (u_bus),
        .lb_we_o       (lb_we),
        .lb_waddr_o    (lb_waddr),
        .lb_wdata_o    (lb_wdata),
        .show_buffer_o (show_buffer),
        .fill_color_o  (fill_color)
    );

    lcd_pixel_out u_pix (
        .pclk          (pclk),
        .resetn        (resetn),
        .lb_we_i       (lb_we),
        .lb_waddr_i    (lb_waddr),
        .lb_wdata_i    (lb_wdata),
        .show_buffer_i (show_buffer),
        .fill_color_i  (fill_color),
        .hsync_act_i   (hsync_act),
        .vsync_act_i   (vsync_act),
        .de_i          (de_raw),
        .rd_addr_i     (rd_addr),
        .lcd_de_o      (lcd_de_o),
        .lcd_hsync_o   (lcd_hsync_o),
        .lcd_vsync_o   (lcd_vsync_o),
        .lcd_r_o       (lcd_r_o),
        .lcd_g_o       (lcd_g_o),
        .lcd_b_o       (lcd_b_o)
    );

endmodule

// ==== source/lcd_timing.sv ====
`timescale 1ns/10ps
`include "lcd_defines.svh"

module lcd_timing (
    input  logic                pclk,
    input  logic                resetn,
    output logic                hsync_act_o,
    output logic                vsync_act_o,
    output logic                de_o,
    output logic [`LB_AW-1:0]   rd_addr_o
);

    localparam logic [`X_W-1:0] H_LAST   = `X_W'(`H_TOTAL);
    localparam logic [`Y_W-1:0] V_LAST   = `Y_W'(`V_TOTAL);
    localparam logic [`X_W-1:0] X_VIS    = `X_W'(`LCD_WIDTH);
    localparam logic [`Y_W-1:0] Y_VIS    = `Y_W'(`LCD_HEIGHT);
    localparam logic [`X_W-1:0] HS_START = `X_W'(`LCD_WIDTH + `H_FRONT_PORCH);
    localparam logic [`X_W-1:0] HS_END   = HS_START + `X_W'(`H_PULSE);
    localparam logic [`Y_W-1:0] VS_START = `Y_W'(`LCD_HEIGHT + `V_FRONT_PORCH);
    localparam logic [`Y_W-1:0] VS_END   = VS_START + `Y_W'(`V_PULSE);

    logic [`X_W-1:0] cnt_x;
    logic [`Y_W-1:0] cnt_y;
    logic [`X_W-1:0] col_m1;
    logic            x_wrap;
    logic            y_wrap;
    logic            in_disp;
    logic            in_hs;
    logic            in_vs;

    assign x_wrap  = (cnt_x == H_LAST);
    assign y_wrap  = (cnt_y == V_LAST);
    assign col_m1  = cnt_x - 1'b1;          // column 1 shows entry 0

    // display area is columns 1..1024 of lines 1..600
    assign in_disp = (cnt_x != '0) && (cnt_x <= X_VIS) &&
                     (cnt_y != '0) && (cnt_y <= Y_VIS);
    assign in_hs   = (cnt_x > HS_START) && (cnt_x < HS_END);    // 15 clocks
    assign in_vs   = (cnt_y > VS_START) && (cnt_y < VS_END);    // 4 lines

    always_ff @(posedge pclk) begin
        if (!resetn) begin
            cnt_x       <= '0;
            cnt_y       <= '0;
            hsync_act_o <= 1'b0;
            vsync_act_o <= 1'b0;
            de_o        <= 1'b0;
        end else begin
            cnt_x       <= x_wrap ? '0 : cnt_x + 1'b1;
            if (x_wrap) begin
                cnt_y   <= y_wrap ? '0 : cnt_y + 1'b1;
            end
            hsync_act_o <= in_hs;
            vsync_act_o <= in_vs;
            de_o        <= in_disp;
        end
    end

    // only meaningful while de_o is high
    always_ff @(posedge pclk) begin
        rd_addr_o <= col_m1[`LB_AW-1:0];
    end

    // porch values must keep the sync pulse out of the visible columns
    a_de_not_in_hsync: assert property (
        @(posedge pclk) disable iff (!resetn) !(de_o && hsync_act_o)
    );

endmodule

// ==== test/lcd_trace.txt ====
// columns: op addr data aux, one record per line, all hex
// op 1 write (aux strobes), 2 read (data expected), 3 watch aux lines, 4 fill aux entries, 0 end
2 00000000 00000000 0   // ctrl after reset
2 00000004 00000000 0   // colour after reset
1 00000000 12345601 1
1 00000000 AB00FF00 8
2 00000000 AB000001 0   // merged bytes
1 00000004 0000F81F 3
1 00000004 FFFF07E0 E   // only byte 1 has storage
2 00000004 0000071F 0
2 00000008 DEADBEEF 0   // unmapped offset
2 0000001C DEADBEEF 0
2 00001000 DEADBEEF 0   // line buffer reads back unmapped
1 0000000C 00000055 F   // write to unmapped offset
2 00000000 AB000001 0
4 00000000 00000000 400 // whole line buffer from the pattern
1 00001014 0000BEEF 1   // entry 5, one strobe writes all of it
1 00001FFC 1234ABCD 4   // entry 3ff, upper data ignored
3 00000000 00000000 2   // buffer scan-out
1 00000000 00000000 1   // clear show_buffer
2 00000000 AB000000 0
3 00000000 00000000 2   // fill colour
1 00000004 0000FFE0 3   // new colour
3 00000000 00000000 1
1 00000000 00000001 1   // back to the buffer
2 00000000 AB000001 0
3 00000000 00000000 1
0 00000000 00000000 0

// ==== test/tb_lcd_checker.sv ====
`timescale 1ns/10ps
`include "lcd_defines.svh"

module tb_lcd_checker (
    input  logic                pclk,
    input  logic                resetn,
    input  logic                host_valid_i,
    input  logic [`BUS_W-1:0]   host_addr_i,
    input  logic [`BUS_W-1:0]   host_wdata_i,
    input  logic [3:0]          host_wstrb_i,
    input  logic [`BUS_W-1:0]   host_rdata_i,
    input  logic                host_ready_i,
    input  logic                lcd_de_i,
    input  logic                lcd_hsync_i,
    input  logic                lcd_vsync_i,
    input  logic [4:0]          lcd_r_i,
    input  logic [5:0]          lcd_g_i,
    input  logic [4:0]          lcd_b_i,
    input  logic                watch_i,
    input  logic [`BUS_W-1:0]   rd_expect_i,
    output int                  value_errs_o,
    output int                  fault_errs_o
);

    localparam int LINE_CLKS = `H_TOTAL + 1;
    localparam int HS_CLKS   = `H_PULSE - 1;
    localparam int IDLE_CLKS = 1200;        // well before the first hsync window
    localparam int PRINT_MAX = 40;

    logic [15:0] lb_model [0:`LCD_WIDTH-1];
    logic [31:0] ctrl_m     = '0;
    logic [15:0] color_m    = '0;
    logic        valid_q    = 1'b0;
    logic        ready_q    = 1'b0;         // predicted ready of the last cycle
    logic        de_q       = 1'b0;
    logic        hs_q       = 1'b1;
    logic        line_on    = 1'b0;         // current line is pixel-checked
    logic        hs_seen    = 1'b0;
    int          de_run     = 0;
    int          hs_run     = 0;
    int          hs_gap     = 0;
    int          rst_cycles = 0;
    int          post_rst   = 0;
    int          value_errs = 0;
    int          fault_errs = 0;

    assign value_errs_o = value_errs;
    assign fault_errs_o = fault_errs;

    initial begin
        for (int i = 0; i < `LCD_WIDTH; i++) begin
            lb_model[i] = '0;
        end
    end

    task automatic value_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
        if (value_errs < PRINT_MAX)
            $display("ERR %s: expected 0x%0h, actual 0x%0h", name, exp, act);
        value_errs++;
    endtask

    task automatic protocol_fault(input string what);
        if (fault_errs < PRINT_MAX) $display("%s at %0t", what, $time);
        fault_errs++;
    endtask

    // bytes land where the strobes say, colour keeps only 16 bits
    task automatic mirror_write();
        logic [2:0] idx;
        idx = host_addr_i[4:2];
        if (host_addr_i[`LB_SEL_BIT]) begin
            lb_model[host_addr_i[11:2]] = host_wdata_i[15:0];
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (host_wstrb_i[i] && idx == 3'd0) ctrl_m[8*i +: 8] = host_wdata_i[8*i +: 8];
                if (host_wstrb_i[i] && idx == 3'd1 && i < 2)
                    color_m[8*i +: 8] = host_wdata_i[8*i +: 8];
            end
        end
    endtask

    always @(posedge pclk) begin
        logic        exp_rdy;
        logic [15:0] exp_pix;
        if (!resetn) begin
            rst_cycles++;
            if (rst_cycles > 1 && (lcd_de_i !== 1'b0 || lcd_hsync_i !== 1'b1 ||
                                   lcd_vsync_i !== 1'b1))
                protocol_fault("panel outputs not idle during reset");
            post_rst = 0;
            valid_q  = 1'b0;
            ready_q  = 1'b0;
            de_q     = 1'b0;
            hs_q     = 1'b1;
            hs_seen  = 1'b0;
            de_run   = 0;
            hs_run   = 0;
        end else begin
            post_rst++;
            if (post_rst < IDLE_CLKS && (lcd_de_i !== 1'b0 || lcd_hsync_i !== 1'b1 ||
                                         lcd_vsync_i !== 1'b1))
                protocol_fault("panel outputs left the idle state too early after reset");

            exp_rdy = valid_q && !ready_q;      // one clock after a fresh valid
            if (host_ready_i !== exp_rdy) value_mismatch("ready_timing", 32'(exp_rdy),
                                                         32'(host_ready_i));
            if (host_ready_i === 1'b1 && host_wstrb_i == 4'h0) begin
                if (host_rdata_i !== rd_expect_i)
                    value_mismatch($sformatf("read %h", host_addr_i), rd_expect_i, host_rdata_i);
            end else if (host_ready_i === 1'b1) begin
                mirror_write();
            end

            if (lcd_de_i === 1'b1 && lcd_hsync_i !== 1'b1)
                protocol_fault("DE high while HSYNC is low");
            if (lcd_de_i === 1'b1) begin
                if (!de_q) line_on = watch_i;
                if (line_on && de_run < `LCD_WIDTH) begin
                    exp_pix = ctrl_m[0] ? lb_model[de_run] : color_m;
                    if ({lcd_r_i, lcd_g_i, lcd_b_i} !== exp_pix)
                        value_mismatch($sformatf("pixel %0d", de_run), 32'(exp_pix),
                                       32'({lcd_r_i, lcd_g_i, lcd_b_i}));
                end
                de_run++;
            end else if (de_q) begin
                if (de_run != `LCD_WIDTH) value_mismatch("de_run", `LCD_WIDTH, 32'(de_run));
                de_run = 0;
            end

            if (lcd_hsync_i === 1'b0) begin
                if (hs_q) begin
                    if (hs_seen && hs_gap != LINE_CLKS)
                        value_mismatch("hs_period", LINE_CLKS, 32'(hs_gap));
                    hs_seen = 1'b1;
                    hs_gap  = 0;
                end
                hs_run++;
            end else if (!hs_q) begin
                if (hs_run != HS_CLKS) value_mismatch("hs_width", HS_CLKS, 32'(hs_run));
                hs_run = 0;
            end
            hs_gap++;

            valid_q = host_valid_i;
            ready_q = exp_rdy;
            de_q    = lcd_de_i;
            hs_q    = lcd_hsync_i;
        end
    end

endmodule

// ==== test/tb_lcd_scanout.sv ====
`timescale 1ns/10ps
`include "lcd_defines.svh"

module tb_lcd_scanout;

    localparam int TRACE_RECS   = 64;
    localparam int BUS_TIMEOUT  = 16;       // cycles to wait for one ready
    localparam int LINE_TIMEOUT = 100000;   // longer than the vertical blank

    logic               pclk;
    logic               resetn;
    logic               host_valid;
    logic [`BUS_W-1:0]  host_addr;
    logic [`BUS_W-1:0]  host_wdata;
    logic [3:0]         host_wstrb;
    logic [`BUS_W-1:0]  host_rdata;
    logic               host_ready;
    logic               lcd_de;
    logic               lcd_hsync;
    logic               lcd_vsync;
    logic [4:0]         lcd_r;
    logic [5:0]         lcd_g;
    logic [4:0]         lcd_b;
    logic               watch;              // pixel checks on for new lines
    logic [`BUS_W-1:0]  rd_expect;
    logic [31:0]        trace_mem [0:4*TRACE_RECS-1];
    logic [15:0]        lfsr;
    int                 run_errs;
    int                 value_errs;
    int                 fault_errs;

    lcd_scanout_top u_dut (
        .pclk (pclk), .resetn (resetn),
        .host_valid_i (host_valid), .host_addr_i (host_addr),
        .host_wdata_i (host_wdata), .host_wstrb_i (host_wstrb),
        .host_rdata_o (host_rdata), .host_ready_o (host_ready),
        .lcd_de_o (lcd_de), .lcd_hsync_o (lcd_hsync), .lcd_vsync_o (lcd_vsync),
        .lcd_r_o (lcd_r), .lcd_g_o (lcd_g), .lcd_b_o (lcd_b)
    );

    tb_lcd_checker u_check (
        .pclk (pclk), .resetn (resetn),
        .host_valid_i (host_valid), .host_addr_i (host_addr),
        .host_wdata_i (host_wdata), .host_wstrb_i (host_wstrb),
        .host_rdata_i (host_rdata), .host_ready_i (host_ready),
        .lcd_de_i (lcd_de), .lcd_hsync_i (lcd_hsync), .lcd_vsync_i (lcd_vsync),
        .lcd_r_i (lcd_r), .lcd_g_i (lcd_g), .lcd_b_i (lcd_b),
        .watch_i (watch), .rd_expect_i (rd_expect),
        .value_errs_o (value_errs), .fault_errs_o (fault_errs)
    );

    // galois form, one step per bit taken
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // odd multiplier keeps every entry distinct
    function automatic logic [15:0] fill_word(input int a);
        logic [31:0] p;
        p = 32'(a) * 32'd40503;
        return p[15:0] ^ 16'hA5C3;
    endfunction

    task automatic idle_gap();
        logic [1:0] g;
        g[0] = lfsr[0];
        lfsr = lfsr_step(lfsr);
        g[1] = lfsr[0];
        lfsr = lfsr_step(lfsr);
        repeat (g) @(posedge pclk);
    endtask

    task automatic bus_xfer(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
        int n;
        n = 0;
        idle_gap();
        host_valid <= 1'b1;
        host_addr  <= addr;
        host_wdata <= data;
        host_wstrb <= strb;
        @(posedge pclk);
        while (host_ready !== 1'b1 && n < BUS_TIMEOUT) begin
            @(posedge pclk);
            n++;
        end
        if (host_ready !== 1'b1) begin
            $display("timeout: no ready for the transfer at address %h", addr);
            run_errs++;
        end
        host_valid <= 1'b0;
        @(posedge pclk);                            // valid low for at least a cycle
    endtask

    task automatic wait_de(input logic level);
        int n;
        n = 0;
        do begin
            @(posedge pclk);
            n++;
        end while (lcd_de !== level && n < LINE_TIMEOUT);
        if (lcd_de !== level) begin
            $display("timeout: DE did not go to %0d", level);
            run_errs++;
        end
    endtask

    task automatic watch_lines(input int lines);
        wait_de(1'b0);                              // skip a line already running
        watch <= 1'b1;
        repeat (lines) begin
            wait_de(1'b1);
            wait_de(1'b0);
        end
        watch <= 1'b0;
    endtask

    task automatic fill_buffer(input int count);
        logic [31:0] lb_base;
        lb_base = 32'd1 << `LB_SEL_BIT;
        for (int a = 0; a < count; a++) begin
            bus_xfer(lb_base | (32'(a) << 2), {16'h0000, fill_word(a)}, 4'hF);
        end
    endtask

    initial begin
        pclk = 1'b0;
        forever #5 pclk = ~pclk;
    end

    initial begin
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] aux;
        int          rec;
        bit          done;
        resetn     = 1'b0;
        host_valid = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        host_wstrb = '0;
        watch      = 1'b0;
        rd_expect  = '0;
        lfsr       = 16'd55;
        run_errs   = 0;
        rec        = 0;
        done       = 1'b0;
        $readmemh("test/lcd_trace.txt", trace_mem);
        repeat (5) @(posedge pclk);
        resetn <= 1'b1;
        while (!done && rec < TRACE_RECS) begin
            op   = trace_mem[4*rec];
            addr = trace_mem[4*rec+1];
            data = trace_mem[4*rec+2];
            aux  = trace_mem[4*rec+3];
            case (op)
                32'd0: done = 1'b1;
                32'd1: bus_xfer(addr, data, aux[3:0]);
                32'd2: begin
                    rd_expect <= data;
                    bus_xfer(addr, '0, 4'h0);
                end
                32'd3: watch_lines(aux);
                32'd4: fill_buffer(aux);
                default: begin
                    $display("trace record %0d holds an unknown command %h", rec, op);
                    run_errs++;
                    done = 1'b1;
                end
            endcase
            rec++;
        end
        repeat (4) @(posedge pclk);
        $display("errors: value %0d, protocol %0d, run %0d", value_errs, fault_errs, run_errs);
        if (value_errs + fault_errs + run_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
